/* Makefile */
# Verilator build and run of the diagnostic path testbench

VERILATOR  ?= verilator
TOP        ?= klDiagTb
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT  ?= TEST PASS

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv) $(wildcard verification/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

/* design/klClkDiag.sv */
`timescale 1ns/100ps
`default_nettype none

module klClkDiag (
  input  wire logic                CLK,
  input  wire logic                rst,
  input  wire klDiagPkg::tEbusDiag bus,
  input  wire logic                burstDec,
  output klDiagPkg::tClkStatus     status,
  output logic                     stepReq,
  output logic                     condStepReq,
  output logic                     burstReq
);

  // Strobe as sampled last cycle
  logic strobeDly;
  // First cycle of a strobe
  logic strobeRise;
  // Decode slot, one cycle after the rise is seen
  logic actPending;

  ////////////////////////////////////////////////////////////////////////////
  // Strobe detect

  assign strobeRise = bus.diagStrobe & ~strobeDly;

  always_ff @(posedge CLK) begin
    if (rst) begin
      strobeDly  <= 1'b0;
      actPending <= 1'b0;
    end else begin
      strobeDly  <= bus.diagStrobe;
      // ds and data hold for the whole strobe so decode can wait a cycle
      actPending <= strobeRise;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Function decode and clock control registers

  always_ff @(posedge CLK) begin
    // Request pulses last one cycle
    stepReq     <= 1'b0;
    condStepReq <= 1'b0;
    burstReq    <= 1'b0;
    if (rst) begin
      // Everything clear except the reset flop
      status           <= '0;
      status.resetFlop <= 1'b1;
    end else begin
      // Burst logic counts the burst counter down
      if (burstDec && (status.burstCount != '0))
        status.burstCount <= status.burstCount - 8'd1;

      if (actPending) begin
        case (bus.ds)
          // Clock control
          klDiagPkg::STOP_CLOCK: begin
            status.running     <= 1'b0;
            status.continueReq <= 1'b0;
          end
          klDiagPkg::START_CLOCK: status.running <= 1'b1;
          klDiagPkg::STEP_CLOCK:  stepReq        <= 1'b1;
          klDiagPkg::COND_STEP:   condStepReq    <= 1'b1;
          klDiagPkg::BURST:       burstReq       <= 1'b1;

          // Flops
          klDiagPkg::CLR_RESET: status.resetFlop   <= 1'b0;
          klDiagPkg::SET_RESET: status.resetFlop   <= 1'b1;
          klDiagPkg::CLR_RUN:   status.runFlop     <= 1'b0;
          klDiagPkg::SET_RUN:   status.runFlop     <= 1'b1;
          // Continue button, held until the clock is stopped
          klDiagPkg::CONTINUE:  status.continueReq <= 1'b1;

          // Burst counter halves, 8 4 2 1 then 128 64 32 16
          klDiagPkg::LOAD_BURST_RH: status.burstCount[3:0] <= bus.data.raw[3:0];
          klDiagPkg::LOAD_BURST_LH: status.burstCount[7:4] <= bus.data.raw[3:0];

          // Source and rate from the clock select view
          klDiagPkg::LOAD_SRC_RATE: begin
            status.src  <= bus.data.clkSel.src;
            status.rate <= bus.data.clkSel.rate;
          end

          // Nibble registers
          klDiagPkg::LOAD_EBOX_DIS: status.eboxDis <= bus.data.raw[3:0];
          klDiagPkg::LOAD_PAR_CHK:  status.parChk  <= bus.data.raw[3:0];
          klDiagPkg::LOAD_MBOX_DIS: status.mboxDis <= bus.data.raw[3:0];

          // Codes handled by other boards
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* design/klClkGate.sv */
`timescale 1ns/100ps
`default_nettype none

module klClkGate #(
  parameter int RATE_MAX_LOG = 3
) (
  input  wire logic                 CLK,
  input  wire logic                 rst,
  input  wire klDiagPkg::tClkStatus status,
  input  wire logic                 stepReq,
  input  wire logic                 condStepReq,
  input  wire logic                 burstReq,
  output logic                      mboxTick,
  output logic                      eboxTick,
  output logic                      burstDec
);

  localparam int BURST_W = $bits(status.burstCount);

  // Free running divider and the mask of bits that must be ones
  logic [RATE_MAX_LOG-1:0] divCnt;
  logic [RATE_MAX_LOG-1:0] divMask;
  logic                    freeTick;
  // Single step and conditional single step
  logic                    stepTick;
  // Ticks still owed after the current one
  logic [BURST_W-1:0]      burstLeft;
  logic                    burstTick;

  ////////////////////////////////////////////////////////////////////////////
  // Tick sources

  // Rate r sets the low r bits of the mask, clipped to the divider width
  always_comb begin
    for (int i = 0; i < RATE_MAX_LOG; i++) begin
      divMask[i] = (i < int'(status.rate));
    end
  end

  // One tick every 2^rate cycles while running
  assign freeTick = status.running && ((divCnt & divMask) == divMask);

  // Conditional step only acts with the clock stopped
  assign stepTick = stepReq | (condStepReq & ~status.running);

  // First burst tick comes straight off the request
  assign burstTick = burstReq ? (status.burstCount != '0) : (burstLeft != '0);

  always_ff @(posedge CLK) begin
    if (rst) begin
      divCnt    <= '0;
      burstLeft <= '0;
      mboxTick  <= 1'b0;
      burstDec  <= 1'b0;
    end else begin
      // Divider restarts from zero each time the clock starts
      divCnt <= status.running ? divCnt + RATE_MAX_LOG'(1) : '0;

      mboxTick <= freeTick | stepTick | burstTick;
      // Each burst tick takes one off the board's burst counter
      burstDec <= burstTick;

      if (burstReq && (status.burstCount != '0))
        burstLeft <= status.burstCount - BURST_W'(1);
      else if (burstLeft != '0)
        burstLeft <= burstLeft - BURST_W'(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // EBOX gating

  // EBOX follows MBOX unless disabled or held in reset
  assign eboxTick = mboxTick & (status.eboxDis == '0) & ~status.resetFlop;

endmodule

`default_nettype wire

/* design/klDiagPkg.sv */
`default_nettype none

package klDiagPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Diagnostic function codes seen by the clock board

  // Codes are octal as in the front-end documentation
  typedef enum logic [6:0] {
    // Clock control
    STOP_CLOCK    = 7'o000,
    START_CLOCK   = 7'o001,
    STEP_CLOCK    = 7'o002,
    COND_STEP     = 7'o004,
    BURST         = 7'o005,
    // Reset, run and continue flops
    CLR_RESET     = 7'o006,
    SET_RESET     = 7'o007,
    CLR_RUN       = 7'o010,
    SET_RUN       = 7'o011,
    CONTINUE      = 7'o012,
    // Register loads from the right half of the bus
    LOAD_BURST_RH = 7'o042,
    LOAD_BURST_LH = 7'o043,
    LOAD_SRC_RATE = 7'o044,
    LOAD_EBOX_DIS = 7'o045,
    LOAD_PAR_CHK  = 7'o046,
    LOAD_MBOX_DIS = 7'o047
  } tDiagFunction;

  // Idle bus code, only meaningful with the strobe low
  localparam tDiagFunction NONE = STOP_CLOCK;

  ////////////////////////////////////////////////////////////////////////////
  // Bus words

  // Right half of the EBUS data word
  typedef union packed {
    logic [17:0] raw;
    // Clock source and rate select as loaded by function 044
    struct packed {
      logic [13:0] pad;
      logic [1:0]  src;
      logic [1:0]  rate;
    } clkSel;
  } tEbusRh;

  // Diagnostic part of the EBUS
  typedef struct packed {
    logic         diagStrobe;
    tDiagFunction ds;
    tEbusRh       data;
  } tEbusDiag;

  // Clock board state as seen from outside
  typedef struct packed {
    logic       running;
    logic       resetFlop;
    logic       runFlop;
    logic       continueReq;
    logic [1:0] src;
    logic [1:0] rate;
    logic [3:0] parChk;
    logic [3:0] mboxDis;
    logic [3:0] eboxDis;
    logic [7:0] burstCount;
  } tClkStatus;

  // Strobe high time and trailing idle gap, in clocks
  localparam int STROBE_CYCLES = 10;
  localparam int GAP_CYCLES    = 4;

endpackage

`default_nettype wire

/* design/klDiagTop.sv */
`timescale 1ns/100ps
`default_nettype none

module klDiagTop #(
  parameter int RATE_MAX_LOG = 3
) (
  input  wire logic                    CLK,
  input  wire logic                    rst,
  input  wire logic                    hostReq,
  input  wire klDiagPkg::tDiagFunction hostFunc,
  input  wire klDiagPkg::tEbusRh       hostData,
  input  wire logic                    resetSeqStart,
  output logic                         busy,
  output logic                         seqDone,
  output klDiagPkg::tClkStatus         status,
  output logic                         mboxTick,
  output logic                         eboxTick
);

  // Diagnostic bus from front-end to clock board
  klDiagPkg::tEbusDiag bus;

  // Clock board requests to the tick logic and the burst count back
  logic stepReq;
  logic condStepReq;
  logic burstReq;
  logic burstDec;

  klFrontEnd frontEnd0 (
    .CLK           (CLK),
    .rst           (rst),
    .hostReq       (hostReq),
    .hostFunc      (hostFunc),
    .hostData      (hostData),
    .resetSeqStart (resetSeqStart),
    .bus           (bus),
    .busy          (busy),
    .seqDone       (seqDone)
  );

  klClkDiag clkDiag0 (
    .CLK         (CLK),
    .rst         (rst),
    .bus         (bus),
    .burstDec    (burstDec),
    .status      (status),
    .stepReq     (stepReq),
    .condStepReq (condStepReq),
    .burstReq    (burstReq)
  );

  klClkGate #(
    .RATE_MAX_LOG (RATE_MAX_LOG)
  ) clkGate0 (
    .CLK         (CLK),
    .rst         (rst),
    .status      (status),
    .stepReq     (stepReq),
    .condStepReq (condStepReq),
    .burstReq    (burstReq),
    .mboxTick    (mboxTick),
    .eboxTick    (eboxTick),
    .burstDec    (burstDec)
  );

endmodule

`default_nettype wire

/* design/klFrontEnd.sv */
`timescale 1ns/100ps
`default_nettype none

module klFrontEnd (
  input  wire logic                    CLK,
  input  wire logic                    rst,
  input  wire logic                    hostReq,
  input  wire klDiagPkg::tDiagFunction hostFunc,
  input  wire klDiagPkg::tEbusRh       hostData,
  input  wire logic                    resetSeqStart,
  output klDiagPkg::tEbusDiag          bus,
  output logic                         busy,
  output logic                         seqDone
);

  // One function is strobe time plus gap time
  localparam int FUNC_CYCLES = klDiagPkg::STROBE_CYCLES + klDiagPkg::GAP_CYCLES;
  localparam int PHASE_W     = $clog2(FUNC_CYCLES);
  // Master reset ROM length
  localparam int ROM_LEN     = 10;
  localparam int STEP_W      = $clog2(ROM_LEN);

  localparam logic [PHASE_W-1:0] STROBE_LAST = PHASE_W'(klDiagPkg::STROBE_CYCLES - 1);
  localparam logic [PHASE_W-1:0] FUNC_LAST   = PHASE_W'(FUNC_CYCLES - 1);
  localparam logic [STEP_W-1:0]  STEP_LAST   = STEP_W'(ROM_LEN - 1);

  logic [PHASE_W-1:0] phase;
  logic [STEP_W-1:0]  stepIdx;
  // Set while walking the ROM, clear for a single host function
  logic               seqMode;
  logic               lastStep;

  ////////////////////////////////////////////////////////////////////////////
  // Master reset ROM

  // Strobed bus word for one ROM step
  function automatic klDiagPkg::tEbusDiag romEntry(input logic [STEP_W-1:0] idx);
    klDiagPkg::tEbusDiag w;
    w = '0;
    w.diagStrobe = 1'b1;
    case (idx)
      STEP_W'(0): w.ds = klDiagPkg::STOP_CLOCK;
      STEP_W'(1): w.ds = klDiagPkg::SET_RESET;
      STEP_W'(2): w.ds = klDiagPkg::LOAD_PAR_CHK;
      STEP_W'(3): w.ds = klDiagPkg::LOAD_MBOX_DIS;
      STEP_W'(4): w.ds = klDiagPkg::LOAD_BURST_RH;
      STEP_W'(5): w.ds = klDiagPkg::LOAD_BURST_LH;
      STEP_W'(6): w.ds = klDiagPkg::LOAD_EBOX_DIS;
      STEP_W'(7): begin
        // 0,,10 gives src 2 and no divide
        w.ds = klDiagPkg::LOAD_SRC_RATE;
        w.data.raw = 18'o000010;
      end
      STEP_W'(8): w.ds = klDiagPkg::START_CLOCK;
      STEP_W'(9): w.ds = klDiagPkg::CLR_RESET;
      // Past the end of the ROM
      default: w = '0;
    endcase
    return w;
  endfunction

  // Host functions behave as a one entry sequence
  assign lastStep = !seqMode || (stepIdx == STEP_LAST);

  ////////////////////////////////////////////////////////////////////////////
  // Bus sequencer

  always_ff @(posedge CLK) begin
    // Done is a single cycle pulse
    seqDone <= 1'b0;
    if (rst) begin
      busy           <= 1'b0;
      seqMode        <= 1'b0;
      phase          <= '0;
      stepIdx        <= '0;
      bus.diagStrobe <= 1'b0;
      bus.ds         <= klDiagPkg::NONE;
      bus.data.raw   <= '0;
    end else if (!busy) begin
      // ROM sequence has priority over a host request
      if (resetSeqStart) begin
        busy    <= 1'b1;
        seqMode <= 1'b1;
        phase   <= '0;
        stepIdx <= '0;
        bus     <= romEntry('0);
      end else if (hostReq) begin
        busy           <= 1'b1;
        seqMode        <= 1'b0;
        phase          <= '0;
        stepIdx        <= '0;
        bus.diagStrobe <= 1'b1;
        bus.ds         <= hostFunc;
        bus.data       <= hostData;
      end
    end else if (phase == STROBE_LAST) begin
      // End of strobe, bus goes idle for the gap
      phase          <= phase + PHASE_W'(1);
      bus.diagStrobe <= 1'b0;
      bus.ds         <= klDiagPkg::NONE;
      bus.data.raw   <= '0;
    end else if (phase == FUNC_LAST) begin
      phase <= '0;
      if (lastStep) begin
        busy    <= 1'b0;
        seqDone <= seqMode;
        seqMode <= 1'b0;
      end else begin
        // Next ROM word goes out with no extra idle cycle
        stepIdx <= stepIdx + STEP_W'(1);
        bus     <= romEntry(stepIdx + STEP_W'(1));
      end
    end else begin
      phase <= phase + PHASE_W'(1);
    end
  end

endmodule

`default_nettype wire

/* flist.f */
design/klDiagPkg.sv
design/klFrontEnd.sv
design/klClkDiag.sv
design/klClkGate.sv
design/klDiagTop.sv
verification/klDiagChk.sv
verification/klDiagTb.sv

/* verification/klDiagChk.sv */
`timescale 1ns/100ps
`default_nettype none

module klDiagChk (
  input wire logic                CLK,
  input wire logic                rst,
  input wire klDiagPkg::tEbusDiag bus,
  input wire logic                eboxTick
);

  // Cycles the strobe has been high so far
  logic [7:0] strobeLen;
  // Reset flop as the bus commands it, set out of reset
  logic       resetCmd;

  always_ff @(posedge CLK) begin
    if (rst) begin
      strobeLen <= '0;
    end else if (bus.diagStrobe) begin
      strobeLen <= strobeLen + 8'd1;
    end else begin
      strobeLen <= '0;
    end
  end

  // Updated in the decode slot on the second strobe cycle
  always_ff @(posedge CLK) begin
    if (rst) begin
      resetCmd <= 1'b1;
    end else if (bus.diagStrobe && (strobeLen == 8'd1)) begin
      if (bus.ds == klDiagPkg::SET_RESET)
        resetCmd <= 1'b1;
      else if (bus.ds == klDiagPkg::CLR_RESET)
        resetCmd <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Diagnostic bus

  // Strobe never runs past its length
  strobeNotLong: assert property (@(posedge CLK) disable iff (rst)
    bus.diagStrobe |-> (strobeLen < 8'(klDiagPkg::STROBE_CYCLES)))
    else $error("diagStrobe high longer than %0d cycles", klDiagPkg::STROBE_CYCLES);

  // And never drops early
  strobeFullLength: assert property (@(posedge CLK) disable iff (rst)
    $fell(bus.diagStrobe) |-> (strobeLen == 8'(klDiagPkg::STROBE_CYCLES)))
    else $error("diagStrobe dropped after %0d cycles", strobeLen);

  // Function and data hold while strobed
  busStable: assert property (@(posedge CLK) disable iff (rst)
    (bus.diagStrobe && $past(bus.diagStrobe)) |-> ($stable(bus.ds) && $stable(bus.data)))
    else $error("ds or data changed during strobe");

  ////////////////////////////////////////////////////////////////////////////
  // Tick outputs

  // No EBOX tick while the bus holds the board in reset
  eboxHeldInReset: assert property (@(posedge CLK) disable iff (rst)
    resetCmd |-> !eboxTick)
    else $error("eboxTick high with resetFlop set");

endmodule

bind klDiagTop klDiagChk chk0 (
  .CLK      (CLK),
  .rst      (rst),
  .bus      (bus),
  .eboxTick (eboxTick)
);

`default_nettype wire

/* verification/klDiagTb.sv */
`timescale 1ns/100ps
`default_nettype none

module klDiagTb;

  // Vector kinds
  localparam logic [3:0] KIND_CMD    = 4'h0;
  localparam logic [3:0] KIND_SEQ    = 4'h1;
  localparam logic [3:0] KIND_WINDOW = 4'h2;
  localparam logic [3:0] KIND_END    = 4'hF;
  localparam int MAX_VECTORS  = 64;
  localparam int RESET_CYCLES = 8;
  // Busy time of one function and of the master reset ROM
  localparam int FUNC_CYCLES  = 14;
  localparam int SEQ_CYCLES   = 140;
  // Tick count field that is not compared
  localparam logic [15:0] NO_CHECK = 16'hFFFF;

  // One line of the vector file
  typedef struct packed {
    logic [3:0]  kind;
    logic [7:0]  func;
    logic [19:0] data;
    logic [15:0] window;
    logic [31:0] status;
    logic [15:0] mboxExp;
    logic [15:0] eboxExp;
  } tVector;

  logic                    CLK = 1'b0;
  logic                    rst;
  logic                    hostReq;
  klDiagPkg::tDiagFunction hostFunc;
  klDiagPkg::tEbusRh       hostData;
  logic                    resetSeqStart;
  logic                    busy;
  logic                    seqDone;
  klDiagPkg::tClkStatus    status;
  logic                    mboxTick;
  logic                    eboxTick;

  logic [$bits(tVector)-1:0] vecMem [MAX_VECTORS];
  int nVec;
  // Running tick totals, sampled between clock edges
  int mboxTotal;
  int eboxTotal;
  int errCount;
  int checkCount;
  int budgetCycles;

  klDiagTop #(
    .RATE_MAX_LOG (3)
  ) i_dut (
    .CLK           (CLK),
    .rst           (rst),
    .hostReq       (hostReq),
    .hostFunc      (hostFunc),
    .hostData      (hostData),
    .resetSeqStart (resetSeqStart),
    .busy          (busy),
    .seqDone       (seqDone),
    .status        (status),
    .mboxTick      (mboxTick),
    .eboxTick      (eboxTick)
  );

  // 10 ns clock
  always #5 CLK = ~CLK;

  // Tick totals, one sample per rising edge
  always @(posedge CLK) begin
    if (rst) begin
      mboxTotal <= 0;
      eboxTotal <= 0;
    end else begin
      mboxTotal <= mboxTotal + int'(mboxTick);
      eboxTotal <= eboxTotal + int'(eboxTick);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  // Falling edge with busy low
  task automatic waitIdle();
    @(negedge CLK);
    while (busy) @(negedge CLK);
  endtask

  // Busy cycles after an accept, ends on the falling edge with busy low
  task automatic measureBusy(output int cycles);
    cycles = 0;
    @(negedge CLK);
    while (busy) begin
      cycles++;
      @(negedge CLK);
    end
  endtask

  task automatic checkBusy(input string name, input int expCycles, input int actCycles);
    checkCount++;
    if (actCycles != expCycles) begin
      errCount++;
      $display("ERR %s busy cycles expected %0d actual %0d", name, expCycles, actCycles);
    end
  endtask

  function automatic string vectorName(input int idx, input tVector v);
    klDiagPkg::tDiagFunction fn;
    fn = klDiagPkg::tDiagFunction'(v.func[6:0]);
    case (v.kind)
      KIND_SEQ:    return $sformatf("vec%0d reset sequence", idx);
      KIND_WINDOW: return $sformatf("vec%0d window %0d", idx, v.window);
      default:     return $sformatf("vec%0d %s", idx, fn.name());
    endcase
  endfunction

  // Issue one vector and compare status and tick counts
  task automatic runVector(input int idx, input tVector v);
    string name;
    int    mboxStart;
    int    eboxStart;
    int    mboxSeen;
    int    eboxSeen;
    int    busyCycles;
    name = vectorName(idx, v);
    waitIdle();
    mboxStart = mboxTotal;
    eboxStart = eboxTotal;
    case (v.kind)
      KIND_CMD: begin
        @(posedge CLK);
        hostReq      <= 1'b1;
        hostFunc     <= klDiagPkg::tDiagFunction'(v.func[6:0]);
        hostData.raw <= v.data[17:0];
        @(posedge CLK);
        hostReq <= 1'b0;
        measureBusy(busyCycles);
        checkBusy(name, FUNC_CYCLES, busyCycles);
        // Host functions never pulse done
        checkCount++;
        if (seqDone !== 1'b0) begin
          errCount++;
          $display("%s: seqDone pulsed after a host function", name);
        end
      end
      KIND_SEQ: begin
        @(posedge CLK);
        resetSeqStart <= 1'b1;
        @(posedge CLK);
        resetSeqStart <= 1'b0;
        measureBusy(busyCycles);
        checkBusy(name, SEQ_CYCLES, busyCycles);
        // Done pulse comes in the cycle busy drops
        checkCount++;
        if (seqDone !== 1'b1) begin
          errCount++;
          $display("%s: seqDone did not pulse when busy fell", name);
        end
      end
      KIND_WINDOW: repeat (v.window) @(negedge CLK);
      default: begin
        errCount++;
        $display("%s: unknown vector kind %h", name, v.kind);
        return;
      end
    endcase
    mboxSeen = mboxTotal - mboxStart;
    eboxSeen = eboxTotal - eboxStart;
    checkCount++;
    if ({4'h0, status} !== v.status) begin
      errCount++;
      $display("ERR %s status expected %h actual %h", name, v.status, {4'h0, status});
    end
    if (v.mboxExp != NO_CHECK) begin
      checkCount++;
      if (mboxSeen != int'(v.mboxExp)) begin
        errCount++;
        $display("ERR %s mboxTick count expected %0d actual %0d", name, v.mboxExp, mboxSeen);
      end
    end
    if (v.eboxExp != NO_CHECK) begin
      checkCount++;
      if (eboxSeen != int'(v.eboxExp)) begin
        errCount++;
        $display("ERR %s eboxTick count expected %0d actual %0d", name, v.eboxExp, eboxSeen);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    tVector v;
    int     cycleSum;
    bit     endFound;
    rst           <= 1'b1;
    hostReq       <= 1'b0;
    hostFunc      <= klDiagPkg::NONE;
    hostData      <= '0;
    resetSeqStart <= 1'b0;
    errCount   = 0;
    checkCount = 0;
    nVec       = 0;
    endFound   = 1'b0;
    cycleSum   = RESET_CYCLES;
    $readmemh("verification/klDiagVectors.txt", vecMem);
    // Count vectors and size the watchdog
    for (int i = 0; i < MAX_VECTORS; i++) begin
      v = tVector'(vecMem[i]);
      if (v.kind == KIND_END) begin
        endFound = 1'b1;
        break;
      end
      nVec++;
      case (v.kind)
        KIND_CMD: cycleSum += FUNC_CYCLES;
        KIND_SEQ: cycleSum += SEQ_CYCLES;
        default:  cycleSum += int'(v.window);
      endcase
    end
    if (!endFound) begin
      errCount++;
      $display("Vector file has no end marker, no vectors run");
      nVec = 0;
    end
    budgetCycles = 2 * cycleSum;
    repeat (RESET_CYCLES) @(posedge CLK);
    rst <= 1'b0;
    for (int i = 0; i < nVec; i++) begin
      runVector(i, tVector'(vecMem[i]));
    end
    $display("checks %0d errors %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog, twice the expected run length
  initial begin
    wait (budgetCycles > 0);
    repeat (budgetCycles) @(posedge CLK);
    $display("Timeout: run still going after %0d cycles", budgetCycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/klDiagVectors.txt */
// kind_func_data_window_status_mbox_ebox, hex; kind 0 command, 1 reset ROM, 2 window, F end
// func is the octal code written in hex; tick count FFFF is not compared
1_00_00000_0000_08800000_FFFF_FFFF
2_00_00000_0010_08800000_0010_0010
0_24_00006_0000_08600000_FFFF_FFFF
2_00_00000_0020_08600000_0008_0008
0_25_00005_0000_08600500_FFFF_FFFF
2_00_00000_0020_08600500_0008_0000
0_25_00000_0000_08600000_FFFF_FFFF
0_07_00000_0000_0C600000_FFFF_FFFF
2_00_00000_0010_0C600000_0004_0000
0_06_00000_0000_08600000_FFFF_FFFF
0_24_0000B_0000_08B00000_FFFF_FFFF
2_00_00000_0040_08B00000_0008_0008
0_04_00000_0000_08B00000_0002_0002
0_00_00000_0000_00B00000_FFFF_FFFF
2_00_00000_0014_00B00000_0000_0000
0_02_00000_0000_00B00000_0001_0001
0_04_00000_0000_00B00000_0001_0001
0_26_3FFF9_0000_00B90000_0000_0000
0_27_00006_0000_00B96000_0000_0000
0_23_0000C_0000_00B960C0_0000_0000
0_22_00005_0000_00B960C5_0000_0000
0_23_00000_0000_00B96005_0000_0000
0_05_00000_0000_00B96000_0005_0005
0_22_00009_0000_00B96009_0000_0000
0_25_00002_0000_00B96209_0000_0000
0_05_00000_0000_00B96200_0009_0000
0_09_00000_0000_02B96200_0000_0000
0_0A_00000_0000_03B96200_0000_0000
0_08_00000_0000_01B96200_0000_0000
0_07_00000_0000_05B96200_0000_0000
0_02_00000_0000_05B96200_0001_0000
0_00_00000_0000_04B96200_0000_0000
0_06_00000_0000_00B96200_0000_0000
0_01_00000_0000_08B96200_FFFF_FFFF
2_00_00000_0028_08B96200_0005_0000
0_24_3FFF4_0000_08496200_FFFF_FFFF
2_00_00000_000C_08496200_000C_0000
F_00_00000_0000_00000000_0000_0000
